/* hdl/exe_pkg.sv */
`default_nettype none

package exe_pkg;

    // datapath widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // divider iteration count and its counter width
    localparam int div_cycles = 32;
    localparam int div_cnt_w  = $clog2(div_cycles + 1);

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_nor,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui,
        alu_passb,
        alu_pc8
    } alu_op_t;

    typedef enum logic [3:0] {
        mem_none,
        mem_lb,
        mem_lbu,
        mem_lh,
        mem_lhu,
        mem_lw,
        mem_lwl,
        mem_lwr,
        mem_sb,
        mem_sh,
        mem_sw,
        mem_swl,
        mem_swr
    } mem_op_t;

    // hi/lo group
    typedef enum logic [3:0] {
        md_none,
        md_mult,
        md_multu,
        md_div,
        md_divu,
        md_mfhi,
        md_mflo,
        md_mthi,
        md_mtlo
    } md_op_t;

    typedef enum logic [1:0] {
        src1_rs,
        src1_sa,
        src1_pc
    } src1_sel_t;

    typedef enum logic [1:0] {
        src2_rt,
        src2_imm_sext,
        src2_imm_zext,
        src2_eight
    } src2_sel_t;

endpackage

`default_nettype wire

/* hdl/alu.sv */
`default_nettype none
`timescale 1ns/1ps

module alu (
    input  exe_pkg::alu_op_t         op,
    input  logic [exe_pkg::xlen-1:0] src1,
    input  logic [exe_pkg::xlen-1:0] src2,
    output logic [exe_pkg::xlen-1:0] result
);
    import exe_pkg::*;

    logic [xlen-1:0] sum;
    logic [xlen-1:0] diff;
    logic [4:0]      shamt;

    assign sum   = src1 + src2;
    assign diff  = src1 - src2;
    // shift amount lives in src1
    assign shamt = src1[4:0];

    always_comb begin
        case (op)
            alu_add:   result = sum;
            alu_sub:   result = diff;
            alu_slt: begin
                result = {{(xlen-1){1'b0}}, $signed(src1) < $signed(src2)};
            end
            alu_sltu: begin
                result = {{(xlen-1){1'b0}}, src1 < src2};
            end
            alu_and:   result = src1 & src2;
            alu_nor:   result = ~(src1 | src2);
            alu_or:    result = src1 | src2;
            alu_xor:   result = src1 ^ src2;
            alu_sll:   result = src2 << shamt;
            alu_srl:   result = src2 >> shamt;
            alu_sra:   result = $signed(src2) >>> shamt;
            alu_lui:   result = {src2[15:0], 16'h0000};
            alu_passb: result = src2;
            // link address, stage feeds eight as src2
            alu_pc8:   result = sum;
            default:   result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/serial_divider.sv */
`default_nettype none
`timescale 1ns/1ps

module serial_divider (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  logic                     is_signed,
    input  logic [exe_pkg::xlen-1:0] dividend,
    input  logic [exe_pkg::xlen-1:0] divisor,
    output logic                     busy,
    output logic                     done,
    output logic [exe_pkg::xlen-1:0] quotient,
    output logic [exe_pkg::xlen-1:0] remainder
);
    import exe_pkg::*;

    logic [xlen-1:0]      dividend_abs;
    logic [xlen-1:0]      divisor_abs;
    logic [xlen-1:0]      q_work;
    logic [xlen-1:0]      r_work;
    logic [xlen-1:0]      d_work;
    logic [xlen:0]        trial;
    logic                 neg_q;
    logic                 neg_r;
    logic [div_cnt_w-1:0] count;
    logic                 last_step;

    assign dividend_abs = (is_signed && dividend[xlen-1]) ? -dividend : dividend;
    assign divisor_abs  = (is_signed && divisor[xlen-1]) ? -divisor : divisor;

    // next dividend bit shifted in, then try the subtract
    assign trial     = {r_work, q_work[xlen-1]} - {1'b0, d_work};
    assign last_step = (count == div_cycles);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            count <= '0;
        end else if (start) begin
            busy  <= 1'b1;
            done  <= 1'b0;
            count <= '0;
        end else if (busy) begin
            if (last_step) begin
                busy <= 1'b0;
                done <= 1'b1;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            q_work <= dividend_abs;
            r_work <= '0;
            d_work <= divisor_abs;
            neg_q  <= is_signed && (dividend[xlen-1] ^ divisor[xlen-1]);
            neg_r  <= is_signed && dividend[xlen-1];
        end else if (busy) begin
            if (last_step) begin
                // sign fixup, remainder follows dividend
                quotient  <= neg_q ? -q_work : q_work;
                remainder <= neg_r ? -r_work : r_work;
            end else if (!trial[xlen]) begin
                r_work <= trial[xlen-1:0];
                q_work <= {q_work[xlen-2:0], 1'b1};
            end else begin
                r_work <= {r_work[xlen-2:0], q_work[xlen-1]};
                q_work <= {q_work[xlen-2:0], 1'b0};
            end
        end
    end

    // a new divide must wait for the running one
    a_no_start_while_busy: assert property (
        @(posedge clk) disable iff (reset) start |-> !busy
    ) else $error("divider started while busy");

endmodule

`default_nettype wire

/* hdl/store_align.sv */
`default_nettype none
`timescale 1ns/1ps

module store_align (
    input  exe_pkg::mem_op_t         mem_op,
    input  logic [1:0]               addr_low,
    input  logic [exe_pkg::xlen-1:0] rt_value,
    output logic [3:0]               wen,
    output logic [exe_pkg::xlen-1:0] wdata
);
    import exe_pkg::*;

    logic [4:0] byte_shift;
    logic [4:0] swl_shift;

    // byte offset in bits
    assign byte_shift = {addr_low, 3'b000};
    // swl moves the top bytes down by 3-k
    assign swl_shift  = {~addr_low, 3'b000};

    always_comb begin
        case (mem_op)
            mem_sb: begin
                wen   = 4'b0001 << addr_low;
                wdata = {4{rt_value[7:0]}};
            end
            mem_sh: begin
                wen   = addr_low[1] ? 4'b1100 : 4'b0011;
                wdata = {2{rt_value[15:0]}};
            end
            mem_sw: begin
                wen   = 4'b1111;
                wdata = rt_value;
            end
            // bytes 0..k
            mem_swl: begin
                wen   = 4'b1111 >> (~addr_low);
                wdata = rt_value >> swl_shift;
            end
            // bytes k..3
            mem_swr: begin
                wen   = 4'b1111 << addr_low;
                wdata = rt_value << byte_shift;
            end
            default: begin
                wen   = 4'b0000;
                wdata = rt_value;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/hilo_unit.sv */
`default_nettype none
`timescale 1ns/1ps

module hilo_unit (
    input  logic                     clk,
    input  logic                     reset,
    input  exe_pkg::md_op_t          md_op,
    input  logic [exe_pkg::xlen-1:0] rs_value,
    input  logic [exe_pkg::xlen-1:0] rt_value,
    input  logic                     start,
    input  logic                     commit,
    output logic [exe_pkg::xlen-1:0] hi,
    output logic [exe_pkg::xlen-1:0] lo,
    output logic                     div_done
);
    import exe_pkg::*;

    logic [2*xlen-1:0] prod_s;
    logic [2*xlen-1:0] prod_u;
    logic [2*xlen-1:0] product;
    logic [xlen-1:0]   quotient;
    logic [xlen-1:0]   remainder;
    logic              div_busy;
    logic              div_done_raw;
    logic              div_issue;
    logic              start_pending;
    logic              is_div_op;

    assign prod_s  = $signed(rs_value) * $signed(rt_value);
    assign prod_u  = rs_value * rt_value;
    assign product = (md_op == md_mult) ? prod_s : prod_u;

    assign is_div_op = (md_op == md_div) || (md_op == md_divu);

    // a flushed divide may still be running when the next one arrives,
    // so hold the request until the divider is free
    assign div_issue = (start || start_pending) && !div_busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            start_pending <= 1'b0;
        end else if (div_issue) begin
            start_pending <= 1'b0;
        end else if (start) begin
            start_pending <= 1'b1;
        end
    end

    // old done stays high until the new divide is loaded
    assign div_done = div_done_raw && !start && !start_pending;

    serial_divider i_divider (
        .clk       (clk),
        .reset     (reset),
        .start     (div_issue),
        .is_signed (md_op == md_div),
        .dividend  (rs_value),
        .divisor   (rt_value),
        .busy      (div_busy),
        .done      (div_done_raw),
        .quotient  (quotient),
        .remainder (remainder)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (commit) begin
            case (md_op)
                md_mult, md_multu: begin
                    hi <= product[2*xlen-1:xlen];
                    lo <= product[xlen-1:0];
                end
                md_div, md_divu: begin
                    hi <= remainder;
                    lo <= quotient;
                end
                md_mthi: hi <= rs_value;
                md_mtlo: lo <= rs_value;
                default: ;
            endcase
        end
    end

    a_div_commit_done: assert property (
        @(posedge clk) disable iff (reset) commit && is_div_op |-> div_done_raw
    ) else $error("divide committed before the divider finished");

endmodule

`default_nettype wire

/* hdl/exe_stage.sv */
`default_nettype none
`timescale 1ns/1ps

module exe_stage (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           flush,
    input  logic                           in_valid,
    input  exe_pkg::alu_op_t               in_alu_op,
    input  exe_pkg::src1_sel_t             in_src1_sel,
    input  exe_pkg::src2_sel_t             in_src2_sel,
    input  logic [15:0]                    in_imm,
    input  logic [exe_pkg::xlen-1:0]       in_rs_value,
    input  logic [exe_pkg::xlen-1:0]       in_rt_value,
    input  logic [exe_pkg::xlen-1:0]       in_pc,
    input  logic [exe_pkg::reg_addr_w-1:0] in_dest,
    input  logic                           in_gr_we,
    input  exe_pkg::mem_op_t               in_mem_op,
    input  exe_pkg::md_op_t                in_md_op,
    input  logic                           ms_allowin,
    output logic                           allowin,
    output logic                           out_valid,
    output logic [exe_pkg::xlen-1:0]       out_result,
    output logic [exe_pkg::reg_addr_w-1:0] out_dest,
    output logic                           out_gr_we,
    output exe_pkg::mem_op_t               out_mem_op,
    output logic                           data_sram_en,
    output logic [3:0]                     data_sram_wen,
    output logic [exe_pkg::xlen-1:0]       data_sram_addr,
    output logic [exe_pkg::xlen-1:0]       data_sram_wdata,
    output logic [exe_pkg::reg_addr_w-1:0] fwd_dest,
    output logic [exe_pkg::xlen-1:0]       fwd_data
);
    import exe_pkg::*;

    logic                  es_valid;
    logic                  ready_go;
    alu_op_t               es_alu_op;
    src1_sel_t             es_src1_sel;
    src2_sel_t             es_src2_sel;
    logic [15:0]           es_imm;
    logic [xlen-1:0]       es_rs_value;
    logic [xlen-1:0]       es_rt_value;
    logic [xlen-1:0]       es_pc;
    logic [reg_addr_w-1:0] es_dest;
    logic                  es_gr_we;
    mem_op_t               es_mem_op;
    md_op_t                es_md_op;
    logic                  es_is_div;
    logic                  div_issued;
    logic                  div_start;
    logic                  div_done;
    logic                  commit;
    logic [xlen-1:0]       alu_src1;
    logic [xlen-1:0]       alu_src2;
    logic [xlen-1:0]       alu_result;
    logic [xlen-1:0]       final_result;
    logic [xlen-1:0]       hi;
    logic [xlen-1:0]       lo;
    logic [3:0]            align_wen;

    assign es_is_div = (es_md_op == md_div) || (es_md_op == md_divu);
    assign ready_go  = !es_is_div || div_done;
    assign allowin   = !es_valid || (ready_go && ms_allowin);
    assign out_valid = es_valid && ready_go;
    assign commit    = out_valid && ms_allowin && !flush;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (flush) begin
            es_valid <= 1'b0;
        end else if (allowin) begin
            es_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && allowin) begin
            es_alu_op   <= in_alu_op;
            es_src1_sel <= in_src1_sel;
            es_src2_sel <= in_src2_sel;
            es_imm      <= in_imm;
            es_rs_value <= in_rs_value;
            es_rt_value <= in_rt_value;
            es_pc       <= in_pc;
            es_dest     <= in_dest;
            es_gr_we    <= in_gr_we;
            es_mem_op   <= in_mem_op;
            es_md_op    <= in_md_op;
        end
    end

    // one start per divide, rearmed by each new instruction
    always_ff @(posedge clk) begin
        if (reset) begin
            div_issued <= 1'b0;
        end else if (in_valid && allowin) begin
            div_issued <= 1'b0;
        end else if (div_start) begin
            div_issued <= 1'b1;
        end
    end

    assign div_start = es_valid && es_is_div && !div_issued;

    always_comb begin
        case (es_src1_sel)
            src1_sa: alu_src1 = {{(xlen-5){1'b0}}, es_imm[10:6]};
            src1_pc: alu_src1 = es_pc;
            default: alu_src1 = es_rs_value;
        endcase
    end

    always_comb begin
        case (es_src2_sel)
            src2_imm_sext: alu_src2 = {{(xlen-16){es_imm[15]}}, es_imm};
            src2_imm_zext: alu_src2 = {{(xlen-16){1'b0}}, es_imm};
            src2_eight:    alu_src2 = 32'd8;
            default:       alu_src2 = es_rt_value;
        endcase
    end

    alu i_alu (
        .op     (es_alu_op),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result)
    );

    hilo_unit i_hilo (
        .clk      (clk),
        .reset    (reset),
        .md_op    (es_md_op),
        .rs_value (es_rs_value),
        .rt_value (es_rt_value),
        .start    (div_start),
        .commit   (commit),
        .hi       (hi),
        .lo       (lo),
        .div_done (div_done)
    );

    store_align i_store (
        .mem_op   (es_mem_op),
        .addr_low (alu_result[1:0]),
        .rt_value (es_rt_value),
        .wen      (align_wen),
        .wdata    (data_sram_wdata)
    );

    assign final_result = (es_md_op == md_mfhi) ? hi :
                          (es_md_op == md_mflo) ? lo : alu_result;

    assign out_result = final_result;
    assign out_dest   = es_dest;
    assign out_gr_we  = es_gr_we;
    assign out_mem_op = es_mem_op;

    // address comes straight from the adder
    assign data_sram_en   = es_valid && (es_mem_op != mem_none);
    assign data_sram_addr = alu_result;
    assign data_sram_wen  = (es_valid && !flush) ? align_wen : 4'b0000;

    assign fwd_dest = es_valid ? es_dest : '0;
    assign fwd_data = es_valid ? final_result : '0;

    a_wen_needs_valid: assert property (
        @(posedge clk) disable iff (reset)
        !es_valid || !(es_mem_op inside {mem_sb, mem_sh, mem_sw, mem_swl, mem_swr})
            |-> data_sram_wen == 4'b0000
    ) else $error("sram write with an empty stage or a non-store");

    // the divider needs many cycles, so a divide never leaves right after its start
    a_div_not_pending: assert property (
        @(posedge clk) disable iff (reset) out_valid && es_is_div |-> !$past(div_start)
    ) else $error("divide left the stage while still pending");

endmodule

`default_nettype wire

/* tb/exe_stage_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module exe_stage_tb;
    import exe_pkg::*;

    localparam int wait_limit = 200;

    logic                  clk;
    logic                  reset;
    logic                  flush;
    logic                  in_valid;
    alu_op_t               in_alu_op;
    src1_sel_t             in_src1_sel;
    src2_sel_t             in_src2_sel;
    logic [15:0]           in_imm;
    logic [xlen-1:0]       in_rs_value;
    logic [xlen-1:0]       in_rt_value;
    logic [xlen-1:0]       in_pc;
    logic [reg_addr_w-1:0] in_dest;
    logic                  in_gr_we;
    mem_op_t               in_mem_op;
    md_op_t                in_md_op;
    logic                  ms_allowin;
    logic                  allowin;
    logic                  out_valid;
    logic [xlen-1:0]       out_result;
    logic [reg_addr_w-1:0] out_dest;
    logic                  out_gr_we;
    mem_op_t               out_mem_op;
    logic                  data_sram_en;
    logic [3:0]            data_sram_wen;
    logic [xlen-1:0]       data_sram_addr;
    logic [xlen-1:0]       data_sram_wdata;
    logic [reg_addr_w-1:0] fwd_dest;
    logic [xlen-1:0]       fwd_data;

    int checks;
    int errors;
    int timeouts;

    exe_stage i_dut (.*);

    always #50 clk = ~clk;

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic logic [31:0] operand1(src1_sel_t sel, logic [15:0] imm,
                                             logic [31:0] rs, logic [31:0] pc);
        case (sel)
            src1_sa: return {27'd0, imm[10:6]};
            src1_pc: return pc;
            default: return rs;
        endcase
    endfunction

    function automatic logic [31:0] operand2(src2_sel_t sel, logic [15:0] imm,
                                             logic [31:0] rt);
        case (sel)
            src2_imm_sext: return {{16{imm[15]}}, imm};
            src2_imm_zext: return {16'd0, imm};
            src2_eight:    return 32'd8;
            default:       return rt;
        endcase
    endfunction

    function automatic logic [31:0] alu_ref(alu_op_t op, logic [31:0] a, logic [31:0] b);
        case (op)
            alu_add, alu_pc8: return a + b;
            alu_sub:  return a - b;
            alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sltu: return (a < b) ? 32'd1 : 32'd0;
            alu_and:  return a & b;
            alu_nor:  return ~(a | b);
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            alu_sll:  return b << a[4:0];
            alu_srl:  return b >> a[4:0];
            alu_sra:  return 32'($signed(b) >>> a[4:0]);
            alu_lui:  return {b[15:0], 16'h0000};
            default:  return b;
        endcase
    endfunction

    function automatic logic [3:0] byte_enables(mem_op_t op, logic [1:0] k);
        case (op)
            mem_sb:  return 4'(4'b0001 << k);
            mem_sh:  return k[1] ? 4'b1100 : 4'b0011;
            mem_sw:  return 4'b1111;
            mem_swl: return 4'((5'd2 << k) - 5'd1);
            mem_swr: return 4'(4'b1111 << k);
            default: return 4'b0000;
        endcase
    endfunction

    function automatic logic [31:0] store_data(mem_op_t op, logic [1:0] k, logic [31:0] rt);
        case (op)
            mem_sb:  return {4{rt[7:0]}};
            mem_sh:  return {2{rt[15:0]}};
            mem_swl: return rt >> (8 * (3 - int'(k)));
            mem_swr: return rt << (8 * int'(k));
            default: return rt;
        endcase
    endfunction

    function automatic logic [63:0] wide_product(logic is_signed, logic [31:0] a,
                                                 logic [31:0] b);
        logic [63:0] ea;
        logic [63:0] eb;
        ea = is_signed ? {{32{a[31]}}, a} : {32'd0, a};
        eb = is_signed ? {{32{b[31]}}, b} : {32'd0, b};
        return ea * eb;
    endfunction

    task automatic divide_ref(input logic is_signed, input logic [31:0] a,
                              input logic [31:0] b, output logic [31:0] q,
                              output logic [31:0] r);
        logic        na;
        logic        nb;
        logic [31:0] ma;
        logic [31:0] mb;
        na = is_signed && a[31];
        nb = is_signed && b[31];
        ma = na ? -a : a;
        mb = nb ? -b : b;
        q = ma / mb;
        r = ma % mb;
        if (na ^ nb)
            q = -q;
        if (na)
            r = -r;
    endtask

    task automatic load_instr(input alu_op_t op, input src1_sel_t s1, input src2_sel_t s2);
        in_alu_op   = op;
        in_src1_sel = s1;
        in_src2_sel = s2;
        in_imm      = 16'($urandom);
        in_rs_value = $urandom;
        in_rt_value = $urandom;
        in_pc       = $urandom & 32'hffff_fffc;
        in_dest     = 5'($urandom);
        in_gr_we    = 1'b1;
        in_mem_op   = mem_none;
        in_md_op    = md_none;
    endtask

    // holds in_valid until the stage takes the instruction
    task automatic enter_stage();
        int cnt;
        in_valid = 1'b1;
        #1;
        cnt = 0;
        while (!allowin && cnt < wait_limit) begin
            @(posedge clk);
            #2;
            cnt++;
        end
        if (!allowin) begin
            timeouts++;
            $display("timeout: allowin never rose at %0t", $time);
        end
        step();
        in_valid = 1'b0;
    endtask

    task automatic issue_md(input md_op_t op);
        load_instr(alu_add, src1_rs, src2_rt);
        in_md_op = op;
        in_gr_we = (op == md_mfhi) || (op == md_mflo);
        enter_stage();
    endtask

    task automatic verify_result(input logic [31:0] exp, input logic [4:0] dest,
                                 input logic we);
        checks++;
        if (out_valid !== 1'b1) begin
            errors++;
            $display("out_valid is low one cycle after entry at %0t", $time);
        end
        compare_value("out_result", out_result, exp);
        compare_value("out_dest", 32'(out_dest), 32'(dest));
        compare_value("out_gr_we", 32'(out_gr_we), 32'(we));
        compare_value("fwd_data", fwd_data, exp);
        compare_value("fwd_dest", 32'(fwd_dest), 32'(dest));
    endtask

    task automatic alu_select_test();
        logic [31:0] exp;
        for (int op = 0; op < 14; op++) begin
            for (int s1 = 0; s1 < 3; s1++) begin
                for (int s2 = 0; s2 < 4; s2++) begin
                    load_instr(alu_op_t'(op), src1_sel_t'(s1), src2_sel_t'(s2));
                    exp = alu_ref(in_alu_op,
                                  operand1(in_src1_sel, in_imm, in_rs_value, in_pc),
                                  operand2(in_src2_sel, in_imm, in_rt_value));
                    enter_stage();
                    verify_result(exp, in_dest, in_gr_we);
                end
            end
        end
    endtask

    task automatic store_test();
        mem_op_t     store_ops [5] = '{mem_sb, mem_sh, mem_sw, mem_swl, mem_swr};
        logic [31:0] addr;
        for (int i = 0; i < 5; i++) begin
            for (int k = 0; k < 4; k++) begin
                load_instr(alu_add, src1_rs, src2_imm_sext);
                in_mem_op   = store_ops[i];
                in_gr_we    = 1'b0;
                in_rs_value = {in_rs_value[31:2], 2'(k)};
                in_imm      = {in_imm[15:2], 2'b00};
                addr        = in_rs_value + {{16{in_imm[15]}}, in_imm};
                enter_stage();
                compare_value("data_sram_wen", 32'(data_sram_wen),
                              32'(byte_enables(in_mem_op, 2'(k))));
                compare_value("data_sram_wdata", data_sram_wdata,
                              store_data(in_mem_op, 2'(k), in_rt_value));
                compare_value("data_sram_addr", data_sram_addr, addr);
                compare_value("out_mem_op", 32'(out_mem_op), 32'(in_mem_op));
            end
        end
        // loads and plain ALU work never write
        for (int op = 0; op < 8; op++) begin
            load_instr(alu_add, src1_rs, src2_imm_sext);
            in_mem_op = mem_op_t'(op);
            enter_stage();
            compare_value("data_sram_wen", 32'(data_sram_wen), 32'd0);
            compare_value("data_sram_en", 32'(data_sram_en), 32'(op != 0));
        end
        // a store that has left must not keep writing
        load_instr(alu_add, src1_rs, src2_imm_sext);
        in_mem_op = mem_sw;
        enter_stage();
        compare_value("data_sram_wen", 32'(data_sram_wen), 32'hf);
        step();
        compare_value("out_valid", 32'(out_valid), 32'd0);
        compare_value("data_sram_wen", 32'(data_sram_wen), 32'd0);
        compare_value("fwd_dest", 32'(fwd_dest), 32'd0);
        compare_value("fwd_data", fwd_data, 32'd0);
    endtask

    task automatic mul_move_test();
        logic [63:0] prod;
        logic [31:0] moved;
        for (int n = 0; n < 6; n++) begin
            issue_md(n[0] ? md_mult : md_multu);
            prod = wide_product(n[0], in_rs_value, in_rt_value);
            issue_md(md_mfhi);
            verify_result(prod[63:32], in_dest, 1'b1);
            issue_md(md_mflo);
            verify_result(prod[31:0], in_dest, 1'b1);
        end
        issue_md(md_mthi);
        moved = in_rs_value;
        issue_md(md_mfhi);
        verify_result(moved, in_dest, 1'b1);
        issue_md(md_mtlo);
        moved = in_rs_value;
        issue_md(md_mflo);
        verify_result(moved, in_dest, 1'b1);
    endtask

    task automatic divide_test();
        logic [31:0] q;
        logic [31:0] r;
        int          cnt;
        for (int n = 0; n < 8; n++) begin
            load_instr(alu_add, src1_rs, src2_rt);
            in_md_op    = n[0] ? md_div : md_divu;
            in_gr_we    = 1'b0;
            in_rt_value = ($urandom % 32'h0001_0000) + 1;
            if (n[0] && ($urandom % 2))
                in_rt_value = -in_rt_value;
            divide_ref(n[0], in_rs_value, in_rt_value, q, r);
            enter_stage();
            cnt = 0;
            while (!out_valid && cnt < wait_limit) begin
                checks++;
                if (allowin !== 1'b0) begin
                    errors++;
                    $display("allowin is high while a divide is pending at %0t", $time);
                end
                step();
                cnt++;
            end
            if (!out_valid) begin
                timeouts++;
                $display("timeout: divide never finished at %0t", $time);
            end else if (cnt < div_cycles) begin
                errors++;
                $display("divide finished after only %0d cycles", cnt);
            end
            issue_md(md_mflo);
            verify_result(q, in_dest, 1'b1);
            issue_md(md_mfhi);
            verify_result(r, in_dest, 1'b1);
        end
    endtask

    task automatic backpressure_test();
        logic [31:0] exp_addr;
        logic [31:0] exp_data;
        logic [4:0]  exp_dest;
        logic [31:0] next_exp;
        load_instr(alu_add, src1_rs, src2_imm_sext);
        in_mem_op = mem_sw;
        exp_addr  = in_rs_value + {{16{in_imm[15]}}, in_imm};
        exp_data  = in_rt_value;
        exp_dest  = in_dest;
        enter_stage();
        ms_allowin = 1'b0;
        // a second instruction waits at the input
        load_instr(alu_sub, src1_rs, src2_rt);
        next_exp = in_rs_value - in_rt_value;
        in_valid = 1'b1;
        repeat (4) begin
            step();
            compare_value("out_valid", 32'(out_valid), 32'd1);
            compare_value("allowin", 32'(allowin), 32'd0);
            compare_value("out_result", out_result, exp_addr);
            compare_value("out_dest", 32'(out_dest), 32'(exp_dest));
            compare_value("data_sram_wen", 32'(data_sram_wen), 32'hf);
            compare_value("data_sram_wdata", data_sram_wdata, exp_data);
            compare_value("data_sram_addr", data_sram_addr, exp_addr);
        end
        ms_allowin = 1'b1;
        step();
        in_valid = 1'b0;
        verify_result(next_exp, in_dest, in_gr_we);
        step();
        compare_value("out_valid", 32'(out_valid), 32'd0);
    endtask

    task automatic flush_test();
        logic [31:0] old_hi;
        issue_md(md_mthi);
        old_hi = in_rs_value;
        step();
        ms_allowin = 1'b0;
        load_instr(alu_add, src1_rs, src2_imm_sext);
        in_mem_op = mem_sw;
        enter_stage();
        compare_value("data_sram_wen", 32'(data_sram_wen), 32'hf);
        flush = 1'b1;
        #1;
        compare_value("data_sram_wen", 32'(data_sram_wen), 32'd0);
        step();
        flush = 1'b0;
        compare_value("out_valid", 32'(out_valid), 32'd0);
        ms_allowin = 1'b1;
        // this mthi must not reach hi
        issue_md(md_mthi);
        flush = 1'b1;
        step();
        flush = 1'b0;
        compare_value("out_valid", 32'(out_valid), 32'd0);
        issue_md(md_mfhi);
        verify_result(old_hi, in_dest, 1'b1);
    endtask

    initial begin
        void'($urandom(32'h63f5_eb7a));
        checks      = 0;
        errors      = 0;
        timeouts    = 0;
        clk         = 1'b0;
        reset       = 1'b1;
        flush       = 1'b0;
        in_valid    = 1'b0;
        in_alu_op   = alu_add;
        in_src1_sel = src1_rs;
        in_src2_sel = src2_rt;
        in_imm      = '0;
        in_rs_value = '0;
        in_rt_value = '0;
        in_pc       = '0;
        in_dest     = '0;
        in_gr_we    = 1'b0;
        in_mem_op   = mem_none;
        in_md_op    = md_none;
        ms_allowin  = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        compare_value("out_valid", 32'(out_valid), 32'd0);
        compare_value("data_sram_wen", 32'(data_sram_wen), 32'd0);
        compare_value("allowin", 32'(allowin), 32'd1);

        alu_select_test();
        store_test();
        mul_move_test();
        divide_test();
        backpressure_test();
        flush_test();

        $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
hdl/exe_pkg.sv
hdl/alu.sv
hdl/serial_divider.sv
hdl/store_align.sv
hdl/hilo_unit.sv
hdl/exe_stage.sv
tb/exe_stage_tb.sv
